//--- design/branch_unit.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module branch_unit (
	input  ex_pkg::dec_t        dec_i,
	input  logic [2:0]          funct3_i,   // branch condition select
	input  logic [`EX_XLEN-1:0] pc_i,
	input  logic [`EX_XLEN-1:0] rs1_i,
	input  logic [`EX_XLEN-1:0] rs2_i,
	output logic [`EX_XLEN-1:0] pc_next_o,
	output logic                link_en_o,  // jal / jalr write rd
	output logic [`EX_XLEN-1:0] link_data_o
);

	logic [`EX_XLEN-1:0] pc_plus4;
	logic [`EX_XLEN-1:0] base;
	logic [`EX_XLEN-1:0] target;
	logic eq;
	logic lt_s;
	logic lt_u;
	logic cond;
	logic taken;

	assign pc_plus4 = pc_i + `EX_PC_STEP;
	assign base = dec_i.is_jalr ? rs1_i : pc_i;
	assign target = base + dec_i.imm; // bit 0 kept as computed

	assign eq = (rs1_i == rs2_i);
	assign lt_s = $signed(rs1_i) < $signed(rs2_i);
	assign lt_u = rs1_i < rs2_i;

	always_comb begin
		case (funct3_i)
			3'b000:  cond = eq;    // beq
			3'b001:  cond = !eq;   // bne
			3'b100:  cond = lt_s;  // blt
			3'b101:  cond = !lt_s; // bge
			3'b110:  cond = lt_u;  // bltu
			3'b111:  cond = !lt_u; // bgeu
			default: cond = 1'b0;
		endcase
	end

	assign taken = dec_i.is_jal || dec_i.is_jalr || (dec_i.is_branch && cond);
	assign pc_next_o = taken ? target : pc_plus4;
	assign link_en_o = dec_i.is_jal || dec_i.is_jalr;
	assign link_data_o = pc_plus4; // return address

endmodule

//--- design/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath and pc width
`define EX_XLEN 32

// instruction word width
`define EX_ILEN 32

`define EX_REG_AW 5 // x0..x31

`define EX_PC_STEP 4 // sequential fetch stride

`endif

//--- design/ex_handshake.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_handshake (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                req_i,
	input  ex_pkg::ex_req_t     req_data_i,
	output ex_pkg::ex_req_t     cap_o,        // captured request to datapath
	input  logic [`EX_XLEN-1:0] alu_result_i,
	input  logic [`EX_XLEN-1:0] pc_next_i,
	input  logic                link_en_i,
	input  logic [`EX_XLEN-1:0] link_data_i,
	input  ex_pkg::dec_t        dec_i,
	output logic                ack_o,
	output ex_pkg::ex_rsp_t     rsp_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY, // datapath evaluating
		ST_ACK   // waiting for req to fall
	} state_e;

	state_e          state_q;
	ex_pkg::ex_req_t cap_q;
	ex_pkg::ex_rsp_t rsp_d;
	ex_pkg::ex_rsp_t rsp_q;

	always_comb begin
		rsp_d.rd_we = dec_i.rd_we && !dec_i.illegal;
		rsp_d.rd_addr = dec_i.rd_addr;
		rsp_d.rd_data = link_en_i ? link_data_i : alu_result_i; // link wins for jumps
		rsp_d.pc_next = pc_next_i;
		rsp_d.illegal = dec_i.illegal;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			rsp_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: if (req_i) state_q <= ST_BUSY;
				ST_BUSY: begin
					rsp_q <= rsp_d;
					state_q <= ST_ACK;
				end
				ST_ACK: if (!req_i) state_q <= ST_IDLE; // four-phase return
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state_q == ST_IDLE) && req_i) begin
			cap_q <= req_data_i; // held until next request
		end
	end

	assign cap_o = cap_q;
	assign ack_o = (state_q == ST_ACK);
	assign rsp_o = rsp_q;

endmodule

//--- design/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		FENCE  = 7'b0001111,
		NOP_OP = 7'b0000001
	} opcode_e;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA,
		OR, AND, MUL, MULH, MULHSU, MULHU, PASS_B
	} alu_op_e;

	// one instruction word, seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic       imm12;   // sign bit
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [`EX_ILEN-13:0] imm20; // upper immediate
			logic [4:0]           rd;
			logic [6:0]           opcode;
		} u_fmt;
		struct packed {
			logic       imm20;   // sign bit
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} inst_u;

	typedef struct packed {
		inst_u               inst;
		logic [`EX_XLEN-1:0] pc;
		logic [`EX_XLEN-1:0] rs1_data;
		logic [`EX_XLEN-1:0] rs2_data;
	} ex_req_t;

	typedef struct packed {
		logic                  rd_we;
		logic [`EX_REG_AW-1:0] rd_addr;
		logic [`EX_XLEN-1:0]   rd_data;
		logic [`EX_XLEN-1:0]   pc_next;
		logic                  illegal;
	} ex_rsp_t;

	typedef struct packed {
		alu_op_e               alu_op;
		logic                  use_imm; // operand b from imm
		logic                  use_pc;  // operand a from pc
		logic [`EX_XLEN-1:0]   imm;
		logic                  is_branch;
		logic                  is_jal;
		logic                  is_jalr;
		logic                  rd_we;
		logic [`EX_REG_AW-1:0] rd_addr;
		logic                  illegal;
	} dec_t;

endpackage

//--- design/ex_top.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_top (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            req_i,
	input  ex_pkg::ex_req_t req_data_i,
	output logic            ack_o,
	output ex_pkg::ex_rsp_t rsp_o
);

	ex_pkg::ex_req_t     cap;        // registered request
	ex_pkg::dec_t        dec;
	logic [`EX_XLEN-1:0] alu_result;
	logic [`EX_XLEN-1:0] pc_next;
	logic                link_en;
	logic [`EX_XLEN-1:0] link_data;

	ex_handshake ex_handshake_i (
		.clk          (clk),
		.reset_i      (reset_i),
		.req_i        (req_i),
		.req_data_i   (req_data_i),
		.cap_o        (cap),
		.alu_result_i (alu_result),
		.pc_next_i    (pc_next),
		.link_en_i    (link_en),
		.link_data_i  (link_data),
		.dec_i        (dec),
		.ack_o        (ack_o),
		.rsp_o        (rsp_o)
	);

	inst_decoder inst_decoder_i (
		.inst_i (cap.inst),
		.dec_o  (dec)
	);

	int_alu int_alu_i (
		.dec_i    (dec),
		.pc_i     (cap.pc),
		.rs1_i    (cap.rs1_data),
		.rs2_i    (cap.rs2_data),
		.result_o (alu_result)
	);

	branch_unit branch_unit_i (
		.dec_i       (dec),
		.funct3_i    (cap.inst.b_fmt.funct3),
		.pc_i        (cap.pc),
		.rs1_i       (cap.rs1_data),
		.rs2_i       (cap.rs2_data),
		.pc_next_o   (pc_next),
		.link_en_o   (link_en),
		.link_data_o (link_data)
	);

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module inst_decoder (
	input  ex_pkg::inst_u inst_i, // instruction word
	output ex_pkg::dec_t  dec_o   // control for alu and branch unit
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`EX_XLEN-1:0] imm_i;
	logic [`EX_XLEN-1:0] imm_b;
	logic [`EX_XLEN-1:0] imm_u;
	logic [`EX_XLEN-1:0] imm_j;

	assign opcode = inst_i.r_fmt.opcode;
	assign funct3 = inst_i.r_fmt.funct3;
	assign funct7 = inst_i.r_fmt.funct7;

	assign imm_i = {{(`EX_XLEN-12){inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12}; // addi, jalr
	assign imm_b = {{(`EX_XLEN-12){inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm11,
		inst_i.b_fmt.imm10_5, inst_i.b_fmt.imm4_1, 1'b0};
	assign imm_u = {inst_i.u_fmt.imm20, 12'h000}; // lui, auipc
	assign imm_j = {{(`EX_XLEN-20){inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm19_12,
		inst_i.j_fmt.imm11, inst_i.j_fmt.imm10_1, 1'b0};

	always_comb begin
		dec_o = '0;
		dec_o.alu_op = ex_pkg::ADD;
		dec_o.rd_addr = inst_i.r_fmt.rd;
		case (opcode)
			ex_pkg::OP_IMM: begin
				dec_o.use_imm = 1'b1;
				dec_o.imm = imm_i;
				dec_o.rd_we = 1'b1;
				case (funct3)
					3'b000: dec_o.alu_op = ex_pkg::ADD;
					3'b010: dec_o.alu_op = ex_pkg::SLT;
					3'b011: dec_o.alu_op = ex_pkg::SLTU;
					3'b100: dec_o.alu_op = ex_pkg::XOR;
					3'b110: dec_o.alu_op = ex_pkg::OR;
					3'b111: dec_o.alu_op = ex_pkg::AND;
					3'b001: begin
						dec_o.alu_op = ex_pkg::SLL;
						dec_o.illegal = (funct7 != 7'b0000000);
					end
					default: begin // srli / srai
						dec_o.alu_op = inst_i.r_fmt.funct7[5] ? ex_pkg::SRA : ex_pkg::SRL;
						dec_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
					end
				endcase
			end
			ex_pkg::OP: begin
				dec_o.rd_we = 1'b1;
				case (funct7)
					7'b0000000: begin
						case (funct3)
							3'b000: dec_o.alu_op = ex_pkg::ADD;
							3'b001: dec_o.alu_op = ex_pkg::SLL;
							3'b010: dec_o.alu_op = ex_pkg::SLT;
							3'b011: dec_o.alu_op = ex_pkg::SLTU;
							3'b100: dec_o.alu_op = ex_pkg::XOR;
							3'b101: dec_o.alu_op = ex_pkg::SRL;
							3'b110: dec_o.alu_op = ex_pkg::OR;
							default: dec_o.alu_op = ex_pkg::AND;
						endcase
					end
					7'b0100000: begin
						case (funct3)
							3'b000: dec_o.alu_op = ex_pkg::SUB;
							3'b101: dec_o.alu_op = ex_pkg::SRA;
							default: dec_o.illegal = 1'b1;
						endcase
					end
					7'b0000001: begin
						case (funct3)
							3'b000: dec_o.alu_op = ex_pkg::MUL;
							3'b001: dec_o.alu_op = ex_pkg::MULH;
							3'b010: dec_o.alu_op = ex_pkg::MULHSU;
							3'b011: dec_o.alu_op = ex_pkg::MULHU;
							default: dec_o.illegal = 1'b1; // no divider
						endcase
					end
					default: dec_o.illegal = 1'b1;
				endcase
			end
			ex_pkg::BRANCH: begin
				dec_o.is_branch = 1'b1;
				dec_o.imm = imm_b;
				dec_o.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
			end
			ex_pkg::JAL: begin
				dec_o.is_jal = 1'b1;
				dec_o.imm = imm_j;
				dec_o.rd_we = 1'b1;
			end
			ex_pkg::JALR: begin
				dec_o.is_jalr = 1'b1;
				dec_o.imm = imm_i;
				dec_o.rd_we = 1'b1;
				dec_o.illegal = (funct3 != 3'b000);
			end
			ex_pkg::LUI: begin
				dec_o.alu_op = ex_pkg::PASS_B;
				dec_o.use_imm = 1'b1;
				dec_o.imm = imm_u;
				dec_o.rd_we = 1'b1;
			end
			ex_pkg::AUIPC: begin
				dec_o.use_pc = 1'b1;
				dec_o.use_imm = 1'b1;
				dec_o.imm = imm_u;
				dec_o.rd_we = 1'b1;
			end
			ex_pkg::FENCE, ex_pkg::NOP_OP: ; // pc advance only
			default: dec_o.illegal = 1'b1; // loads, stores, system and the rest
		endcase
		if (dec_o.illegal) begin
			dec_o.rd_we = 1'b0;
			dec_o.is_branch = 1'b0;
			dec_o.is_jal = 1'b0;
			dec_o.is_jalr = 1'b0;
		end
		if (!dec_o.rd_we) begin
			dec_o.rd_addr = '0; // no destination
		end
	end

endmodule

//--- design/int_alu.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module int_alu (
	input  ex_pkg::dec_t        dec_i,   // decoded control
	input  logic [`EX_XLEN-1:0] pc_i,
	input  logic [`EX_XLEN-1:0] rs1_i,
	input  logic [`EX_XLEN-1:0] rs2_i,
	output logic [`EX_XLEN-1:0] result_o // register write data
);

	logic [`EX_XLEN-1:0] op_a;
	logic [`EX_XLEN-1:0] op_b;
	logic [4:0] shamt;
	logic sign_a;
	logic sign_b;
	logic signed [`EX_XLEN:0] mul_a;
	logic signed [`EX_XLEN:0] mul_b;
	logic signed [2*`EX_XLEN+1:0] mul_res;
	logic lt_s;
	logic lt_u;

	assign op_a = dec_i.use_pc ? pc_i : rs1_i; // auipc takes pc
	assign op_b = dec_i.use_imm ? dec_i.imm : rs2_i;
	assign shamt = op_b[4:0];

	// sign extension of the 33-bit multiplier inputs per variant
	assign sign_a = (dec_i.alu_op == ex_pkg::MUL) || (dec_i.alu_op == ex_pkg::MULH) ||
		(dec_i.alu_op == ex_pkg::MULHSU);
	assign sign_b = (dec_i.alu_op == ex_pkg::MUL) || (dec_i.alu_op == ex_pkg::MULH);
	assign mul_a = {sign_a & op_a[`EX_XLEN-1], op_a};
	assign mul_b = {sign_b & op_b[`EX_XLEN-1], op_b};
	assign mul_res = (2*`EX_XLEN+2)'(mul_a) * (2*`EX_XLEN+2)'(mul_b); // one shared signed multiplier

	assign lt_s = $signed(op_a) < $signed(op_b);
	assign lt_u = op_a < op_b;

	always_comb begin
		case (dec_i.alu_op)
			ex_pkg::ADD:    result_o = op_a + op_b;
			ex_pkg::SUB:    result_o = op_a - op_b;
			ex_pkg::SLL:    result_o = op_a << shamt;
			ex_pkg::SLT:    result_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
			ex_pkg::SLTU:   result_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
			ex_pkg::XOR:    result_o = op_a ^ op_b;
			ex_pkg::SRL:    result_o = op_a >> shamt;
			ex_pkg::SRA:    result_o = $signed(op_a) >>> shamt; // sign fill
			ex_pkg::OR:     result_o = op_a | op_b;
			ex_pkg::AND:    result_o = op_a & op_b;
			ex_pkg::MUL:    result_o = mul_res[`EX_XLEN-1:0];
			ex_pkg::MULH,
			ex_pkg::MULHSU,
			ex_pkg::MULHU:  result_o = mul_res[2*`EX_XLEN-1:`EX_XLEN]; // upper half
			ex_pkg::PASS_B: result_o = op_b; // lui
			default:        result_o = '0;
		endcase
	end

endmodule

//--- dv/ex_sva.sv
`timescale 1ns/1ps

module ex_sva (
	input logic            clk,
	input logic            reset_i,
	input logic            req_i,
	input logic            ack_i, // ack_o of the DUT
	input ex_pkg::ex_rsp_t rsp_i  // rsp_o of the DUT
);

	ack_after_reset: assert property (@(posedge clk) reset_i |=> !ack_i)
		else $error("ack_o is high in the cycle after reset");

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
		$rose(ack_i) |-> req_i)
		else $error("ack_o rose while req_i was low");

	rsp_held: assert property (@(posedge clk) disable iff (reset_i)
		ack_i && $past(ack_i) |-> $stable(rsp_i))
		else $error("rsp_o changed while ack_o was high");

	ack_release: assert property (@(posedge clk) disable iff (reset_i)
		ack_i && !req_i |=> !ack_i)
		else $error("ack_o stayed high after req_i was sampled low");

endmodule

bind ex_top ex_sva ex_sva_i (
	.clk     (clk),
	.reset_i (reset_i),
	.req_i   (req_i),
	.ack_i   (ack_o),
	.rsp_i   (rsp_o)
);

//--- dv/ex_tb.sv
`timescale 1ns/1ps

module ex_tb;

	localparam int N_TRANS = 300;
	localparam int TIMEOUT_CYCLES = N_TRANS * 6 + 50; // at most 6 cycles per transaction

	logic            clk = 1'b0;
	logic            reset_i;
	logic            req_i;
	ex_pkg::ex_req_t req_data_i;
	logic            ack_o;
	ex_pkg::ex_rsp_t rsp_o;
	logic [31:0]     rng_state = 32'd14137;
	int              cycle_cnt = 0;
	int              data_errs = 0;
	int              hs_errs = 0;

	ex_top ex_top_i (
		.clk        (clk),
		.reset_i    (reset_i),
		.req_i      (req_i),
		.req_data_i (req_data_i),
		.ack_o      (ack_o),
		.rsp_o      (rsp_o)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13); // xorshift32
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [31:0] pick_operand();
		case (next_rand() % 8)
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h8000_0000;
			3: return 32'h7fff_ffff;
			default: return next_rand();
		endcase
	endfunction

	function automatic logic [31:0] make_inst();
		logic [31:0] w;
		logic [31:0] s;
		w = next_rand(); // random fields, opcode fixed below
		s = next_rand();
		case (next_rand() % 10)
			0: begin
				w[6:0] = 7'h13;
				if (w[14:12] == 3'd1 && s[3:0] != 4'd0) w[31:25] = 7'h00;
				if (w[14:12] == 3'd5) w[31:25] = {1'b0, s[0], 5'b0};
			end
			1: begin
				w[6:0] = 7'h33;
				w[31:25] = {1'b0, s[0], 5'b0};
			end
			2: begin // mul family
				w[6:0] = 7'h33;
				w[31:25] = 7'h01;
				w[14] = 1'b0;
			end
			3: begin
				w[6:0] = 7'h63;
				if (w[14:13] == 2'b01) w[13] = 1'b0; // keep to the six real conditions
			end
			4: w[6:0] = 7'h6f;
			5: begin
				w[6:0] = 7'h67;
				w[14:12] = 3'd0;
			end
			6: w[6:0] = 7'h37;
			7: w[6:0] = 7'h17;
			8: w[6:0] = s[0] ? 7'h0f : 7'h01;
			default: begin
				case (s[3:1])
					0: w[6:0] = 7'h03; // load
					1: w[6:0] = 7'h23; // store
					2: w[6:0] = 7'h73; // system
					3: w = {7'h01, w[24:15], 1'b1, w[13:12], w[11:7], 7'h33}; // div/rem
					4: w = {7'h41, w[24:7], 7'h33}; // bad funct7
					5: w = {w[31:15], 3'b010, w[11:7], 7'h63};
					6: w = {w[31:15], 3'b001, w[11:7], 7'h67};
					default: ; // any word
				endcase
			end
		endcase
		return w;
	endfunction

	function automatic logic [31:0] base_op(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << sh;
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? ((a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh))) : a >> sh;
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] mul_op(input logic [1:0] kind, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] xa;
		logic [63:0] xb;
		logic [63:0] p;
		xa = {(kind != 2'd3) ? {32{a[31]}} : 32'd0, a}; // mulhu takes a unsigned
		xb = {(kind[1] == 1'b0) ? {32{b[31]}} : 32'd0, b}; // signed b for mul, mulh
		p = xa * xb;
		return (kind == 2'd0) ? p[31:0] : p[63:32];
	endfunction

	function automatic ex_pkg::ex_rsp_t expect_rsp(input logic [31:0] w, input logic [31:0] pc,
		input logic [31:0] a, input logic [31:0] b);
		ex_pkg::ex_rsp_t e;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic        ok;
		logic        take;
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		e = '0;
		e.rd_addr = w[11:7];
		e.pc_next = pc + 32'd4;
		ok = 1'b1;
		take = 1'b0;
		case (w[6:0])
			7'h13: begin
				e.rd_we = 1'b1;
				ok = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
				e.rd_data = base_op(f3, f3 == 3'd5 && f7[5], a, imm_i);
			end
			7'h33: begin
				e.rd_we = 1'b1;
				if (f7 == 7'h01) begin
					ok = !f3[2];
					e.rd_data = mul_op(f3[1:0], a, b);
				end else begin
					ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
					e.rd_data = base_op(f3, f7[5], a, b);
				end
			end
			7'h63: begin
				ok = (f3[2:1] != 2'b01);
				case (f3)
					3'd0: take = (a == b);
					3'd1: take = (a != b);
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					default: take = a >= b;
				endcase
				if (take) e.pc_next = pc + imm_b;
			end
			7'h6f: begin
				e.rd_we = 1'b1;
				e.rd_data = pc + 32'd4;
				e.pc_next = pc + imm_j;
			end
			7'h67: begin
				ok = (f3 == 3'd0);
				e.rd_we = 1'b1;
				e.rd_data = pc + 32'd4;
				e.pc_next = a + imm_i; // bit 0 kept
			end
			7'h37: begin
				e.rd_we = 1'b1;
				e.rd_data = {w[31:12], 12'h000};
			end
			7'h17: begin
				e.rd_we = 1'b1;
				e.rd_data = pc + {w[31:12], 12'h000};
			end
			7'h0f, 7'h01: ; // fence and nop
			default: ok = 1'b0;
		endcase
		if (!ok) begin
			e.rd_we = 1'b0;
			e.pc_next = pc + 32'd4;
		end
		e.illegal = !ok;
		return e;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		assert (got === exp) else begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			data_errs++;
		end
	endtask

	task automatic run_one(input ex_pkg::ex_req_t req);
		ex_pkg::ex_rsp_t exp;
		ex_pkg::ex_rsp_t held;
		int n;
		int hold;
		exp = expect_rsp(req.inst, req.pc, req.rs1_data, req.rs2_data);
		@(posedge clk);
		req_data_i <= req;
		req_i <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!ack_o && n < 8);
		assert (ack_o && n == 3) else begin
			$display("handshake error at %0t: ack_o did not rise one cycle after capture", $time);
			hs_errs++;
		end
		compare_field("rsp_o.illegal", 32'(exp.illegal), 32'(rsp_o.illegal));
		compare_field("rsp_o.rd_we", 32'(exp.rd_we), 32'(rsp_o.rd_we));
		compare_field("rsp_o.pc_next", exp.pc_next, rsp_o.pc_next);
		if (exp.rd_we) begin // address and data only matter on a write
			compare_field("rsp_o.rd_addr", 32'(exp.rd_addr), 32'(rsp_o.rd_addr));
			compare_field("rsp_o.rd_data", exp.rd_data, rsp_o.rd_data);
		end
		held = rsp_o;
		hold = int'(next_rand() % 2);
		repeat (hold) begin
			@(negedge clk);
			assert (ack_o && rsp_o == held) else begin
				$display("handshake error at %0t: ack_o or rsp_o changed while req_i was held",
					$time);
				hs_errs++;
			end
		end
		@(posedge clk);
		req_i <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack_o && n < 8);
		assert (!ack_o && n == 2) else begin
			$display("handshake error at %0t: ack_o did not fall after req_i dropped", $time);
			hs_errs++;
		end
	endtask

	initial begin
		ex_pkg::ex_req_t req;
		reset_i <= 1'b1;
		req_i <= 1'b0;
		req_data_i <= '0;
		repeat (4) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		assert (!ack_o) else begin
			$display("handshake error at %0t: ack_o is high after reset", $time);
			hs_errs++;
		end
		for (int i = 0; i < N_TRANS; i++) begin
			req.inst = make_inst();
			req.pc = next_rand() & 32'hffff_fffc;
			req.rs1_data = pick_operand();
			req.rs2_data = (next_rand() % 8 == 0) ? req.rs1_data : pick_operand(); // equal operands
			run_one(req);
		end
		$display("done: %0d transactions, %0d data errors, %0d handshake errors",
			N_TRANS, data_errs, hs_errs);
		if (data_errs == 0 && hs_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+design
design/ex_pkg.sv
design/inst_decoder.sv
design/int_alu.sv
design/branch_unit.sv
design/ex_handshake.sv
design/ex_top.sv
dv/ex_sva.sv
dv/ex_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ex_tb -f filelist.f -o ex_sim ||
	{ echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/ex_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1
